// File: mem_stage.f
verilog/mem_pkg.sv
verilog/cache_pkg.sv
verilog/mem_addr_gen.sv
verilog/mem_load_align.sv
verilog/mem_ctrl.sv
verilog/dmem_model.sv
verilog/mem_stage_top.sv
test/mem_stage_tb.sv

// File: test/mem_stage_tb.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_tb;

    localparam int unsigned lat = 3;
    localparam int unsigned wait_limit = 200;

    logic              clk;
    logic              arst_n;
    logic              in_valid;
    mem_pkg::mem_req_t in_req;
    logic              stall;
    logic              wb_valid;
    mem_pkg::mem_wb_t  wb;

    // mirror of the data memory
    logic [31:0] mirror [0:(1 << cache_pkg::addr_word_bits)-1];
    logic [15:0] lfsr_state = 16'd17;
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;
    int          accepted = 0;
    int          results = 0;

    // outstanding expectations in arrival order
    mem_pkg::mem_wb_t exp_q[$];
    string            name_q[$];
    int               due_q[$];
    bit               load_q[$];

    mem_stage_top #(
        .mem_latency (lat)
    ) dut0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .in_req   (in_req),
        .stall    (stall),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // rising edge count read on falling edges
    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic lfsr_step();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_step()};
        end
        return v;
    endfunction

    // 32-word region with random tag and random base/imm split
    function automatic mem_pkg::mem_req_t make_req(input mem_pkg::mem_op_e op,
            input mem_pkg::mem_width_e width, input logic uns, input logic [4:0] word,
            input logic [1:0] off, input logic [31:0] data);
        mem_pkg::mem_req_t r;
        logic [31:0]       tag;
        logic [31:0]       imm;
        logic [31:0]       addr;
        tag = rand_bits(20);
        imm = rand_bits(12);
        addr = {tag[19:0], 5'b00000, word, off};
        r.op = op;
        r.width = width;
        r.load_unsigned = uns;
        r.rd = 5'(rand_bits(5));
        // 12-bit signed immediate
        r.imm = {{20{imm[11]}}, imm[11:0]};
        r.base = addr - r.imm;
        r.store_data = data;
        return r;
    endfunction

    // expected write-back while stores update the mirror
    function automatic mem_pkg::mem_wb_t ref_access(input mem_pkg::mem_req_t req);
        mem_pkg::mem_wb_t                     res;
        logic [31:0]                          addr;
        logic [cache_pkg::addr_word_bits-1:0] w;
        logic [1:0]                           off;
        logic [31:0]                          word;
        logic [7:0]                           b;
        logic [15:0]                          h;
        addr = req.base + req.imm;
        w = addr[11:2];
        off = addr[1:0];
        res.rd = req.rd;
        res.data = '0;
        res.exc = mem_pkg::exc_none;
        if ((req.width == mem_pkg::width_half && off[0]) ||
                (req.width == mem_pkg::width_word && off != 2'b00)) begin
            res.exc = mem_pkg::exc_ale;
            return res;
        end
        word = mirror[w];
        if (req.op == mem_pkg::op_store) begin
            case (req.width)
                mem_pkg::width_byte: word[8*off +: 8] = req.store_data[7:0];
                mem_pkg::width_half: word[8*off +: 16] = req.store_data[15:0];
                default: word = req.store_data;
            endcase
            mirror[w] = word;
        end else begin
            b = word[8*off +: 8];
            h = word[8*off +: 16];
            case (req.width)
                mem_pkg::width_byte:
                    res.data = req.load_unsigned ? {24'b0, b} : {{24{b[7]}}, b};
                mem_pkg::width_half:
                    res.data = req.load_unsigned ? {16'b0, h} : {{16{h[15]}}, h};
                default: res.data = word;
            endcase
        end
        return res;
    endfunction

    task automatic abort_run(input string what);
        errors++;
        $display("timeout: %s", what);
        $display("checks %0d, errors %0d, accepted %0d, results %0d",
                 checks, errors, accepted, results);
        $display("STATUS: FAIL");
        $finish;
    endtask

    // starts on a falling edge and returns on the one after acceptance
    task automatic send(input mem_pkg::mem_req_t req, input string name);
        mem_pkg::mem_wb_t exp;
        int               waited;
        in_valid = 1'b1;
        in_req = req;
        waited = 0;
        while (stall && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            abort_run($sformatf("%s never accepted, stall stuck high", name));
        end else begin
            // stall low now so the next rising edge accepts
            exp = ref_access(req);
            exp_q.push_back(exp);
            name_q.push_back(name);
            load_q.push_back(req.op == mem_pkg::op_load && exp.exc == mem_pkg::exc_none);
            due_q.push_back(cycle + 1 + ((exp.exc == mem_pkg::exc_none) ? lat + 2 : 1));
            accepted++;
            @(negedge clk);
            in_valid = 1'b0;
            if (stall !== 1'b1) begin
                errors++;
                $display("%s: stall not raised after acceptance", name);
            end
        end
    endtask

    task automatic compare_result();
        mem_pkg::mem_wb_t exp;
        string            name;
        int               due;
        bit               is_load;
        if (exp_q.size() == 0) begin
            errors++;
            $display("write-back at edge %0d with no access outstanding", cycle);
            return;
        end
        exp = exp_q.pop_front();
        name = name_q.pop_front();
        due = due_q.pop_front();
        is_load = load_q.pop_front();
        results++;
        checks++;
        if (wb.rd !== exp.rd) begin
            errors++;
            $display("** Error %s: rd expected %0d actual %0d", name, exp.rd, wb.rd);
        end
        if (wb.exc !== exp.exc) begin
            errors++;
            $display("** Error %s: exc expected %0h actual %0h", name, exp.exc, wb.exc);
        end
        // store data is not checked
        if (is_load && wb.data !== exp.data) begin
            errors++;
            $display("** Error %s: data expected %08h actual %08h", name, exp.data, wb.data);
        end
        if (cycle != due) begin
            errors++;
            $display("** Error %s: wb edge expected %0d actual %0d", name, due, cycle);
        end
    endtask

    // wb is stable between rising edges
    always @(negedge clk) begin
        if (arst_n && wb_valid) begin
            compare_result();
        end
    end

    initial begin
        mem_pkg::mem_op_e    op;
        mem_pkg::mem_width_e wd;
        logic [31:0]         v;
        int                  waited;
        in_valid = 1'b0;
        in_req = '0;
        arst_n = 1'b0;
        repeat (16) @(negedge clk);
        arst_n = 1'b1;
        @(negedge clk);
        // fill the region so no load sees unknown data
        for (int w = 0; w < 32; w++) begin
            send(make_req(mem_pkg::op_store, mem_pkg::width_word, 1'b0, 5'(w), 2'd0,
                          rand_bits(32)), "preload");
        end
        // word store then load with the neighbour untouched
        send(make_req(mem_pkg::op_store, mem_pkg::width_word, 1'b0, 5'd3, 2'd0,
                      32'h1234_5678), "word_store");
        send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd3, 2'd0, 0), "word_load");
        send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd4, 2'd0, 0), "other_word");
        // partial stores merge into the word
        for (int o = 0; o < 4; o++) begin
            send(make_req(mem_pkg::op_store, mem_pkg::width_byte, 1'b0, 5'd5, 2'(o),
                          rand_bits(32)), "byte_merge");
            send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd5, 2'd0, 0),
                 "byte_merge_check");
        end
        for (int o = 0; o < 4; o += 2) begin
            send(make_req(mem_pkg::op_store, mem_pkg::width_half, 1'b0, 5'd6, 2'(o),
                          rand_bits(32)), "half_merge");
            send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd6, 2'd0, 0),
                 "half_merge_check");
        end
        // negative and positive lanes for extension
        send(make_req(mem_pkg::op_store, mem_pkg::width_word, 1'b0, 5'd7, 2'd0,
                      32'h8071_F00E), "ext_setup");
        send(make_req(mem_pkg::op_store, mem_pkg::width_word, 1'b0, 5'd8, 2'd0,
                      32'h7F8E_0C91), "ext_setup");
        for (int w = 7; w < 9; w++) begin
            for (int u = 0; u < 2; u++) begin
                for (int o = 0; o < 4; o++) begin
                    send(make_req(mem_pkg::op_load, mem_pkg::width_byte, 1'(u), 5'(w),
                                  2'(o), 0), "byte_load");
                end
                for (int o = 0; o < 4; o += 2) begin
                    send(make_req(mem_pkg::op_load, mem_pkg::width_half, 1'(u), 5'(w),
                                  2'(o), 0), "half_load");
                end
            end
        end
        // misaligned accesses leave memory alone
        for (int o = 1; o < 4; o++) begin
            if (o != 2) begin
                send(make_req(mem_pkg::op_store, mem_pkg::width_half, 1'b0, 5'd9, 2'(o),
                              rand_bits(32)), "misaligned_half");
                send(make_req(mem_pkg::op_load, mem_pkg::width_half, 1'b0, 5'd9, 2'(o), 0),
                     "misaligned_half");
            end
            send(make_req(mem_pkg::op_store, mem_pkg::width_word, 1'b0, 5'd9, 2'(o),
                          rand_bits(32)), "misaligned_word");
            send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd9, 2'(o), 0),
                 "misaligned_word");
        end
        send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'd9, 2'd0, 0),
             "misaligned_check");
        // random mix back to back
        for (int n = 0; n < 48; n++) begin
            v = rand_bits(2);
            case (v[1:0])
                2'd0: wd = mem_pkg::width_byte;
                2'd1: wd = mem_pkg::width_half;
                default: wd = mem_pkg::width_word;
            endcase
            v = rand_bits(1);
            op = mem_pkg::mem_op_e'(v[0]);
            v = rand_bits(8);
            send(make_req(op, wd, v[7], v[6:2], v[1:0], rand_bits(32)), "random_mix");
        end
        // read back the whole region
        for (int w = 0; w < 32; w++) begin
            send(make_req(mem_pkg::op_load, mem_pkg::width_word, 1'b0, 5'(w), 2'd0, 0),
                 "final_sweep");
        end
        waited = 0;
        while (results != accepted && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (results != accepted) begin
            abort_run("write-back results missing after last access");
        end else begin
            // extra write-backs would show up while idle
            repeat (10) @(negedge clk);
            if (results != accepted || stall !== 1'b0) begin
                errors++;
                $display("accepted %0d but got %0d results, stall %b",
                         accepted, results, stall);
            end
            $display("checks %0d, errors %0d, accepted %0d, results %0d",
                     checks, errors, accepted, results);
            if (errors == 0) begin
                $display("STATUS: PASS");
            end else begin
                $display("STATUS: FAIL");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/mem_stage_top.sv
`timescale 1ns/1ns
`default_nettype none

module mem_stage_top #(
    parameter int unsigned mem_latency = 3
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     in_valid,
    input  wire mem_pkg::mem_req_t  in_req,
    output logic                    stall,
    output logic                    wb_valid,
    output mem_pkg::mem_wb_t        wb
);

    mem_pkg::mem_req_t     held_req;
    cache_pkg::cache_req_t creq;
    mem_pkg::mem_exc_e     exc;
    logic                  cache_valid;
    logic                  addr_valid;
    logic                  data_valid;
    logic [31:0]           rdata;
    logic [31:0]           ldata;

    // sequencing and stage register
    mem_ctrl u_ctrl (
        .clk         (clk),
        .arst_n      (arst_n),
        .in_valid    (in_valid),
        .in_req      (in_req),
        .stall       (stall),
        .cache_valid (cache_valid),
        .creq_in     (creq),
        .exc_in      (exc),
        .addr_valid  (addr_valid),
        .data_valid  (data_valid),
        .ldata       (ldata),
        .held_req    (held_req),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    // first half, from the held request
    mem_addr_gen u_addr_gen (
        .req  (held_req),
        .creq (creq),
        .exc  (exc)
    );

    // second half, offset still valid from the held request
    mem_load_align u_load_align (
        .rdata         (rdata),
        .offset        (creq.offset[1:0]),
        .width         (held_req.width),
        .load_unsigned (held_req.load_unsigned),
        .ldata         (ldata)
    );

    // stands in for the data cache
    dmem_model #(
        .mem_latency (mem_latency)
    ) u_dmem (
        .clk         (clk),
        .arst_n      (arst_n),
        .cache_valid (cache_valid),
        .creq        (creq),
        .addr_valid  (addr_valid),
        .data_valid  (data_valid),
        .rdata       (rdata)
    );

endmodule

`default_nettype wire

// File: verilog/dmem_model.sv
`timescale 1ns/1ns
`default_nettype none

module dmem_model #(
    parameter int unsigned mem_latency = 3
) (
    input  wire                         clk,
    input  wire                         arst_n,
    input  wire                         cache_valid,
    input  wire cache_pkg::cache_req_t  creq,
    output logic                        addr_valid,
    output logic                        data_valid,
    output logic [31:0]                 rdata
);

    localparam int unsigned depth = 1 << cache_pkg::addr_word_bits;

    // word storage, contents survive reset
    logic [31:0] mem [0:depth-1];

    logic [cache_pkg::addr_word_bits-1:0] waddr;
    // cycles left until the response
    logic [3:0]  count;
    logic        busy;

    // index plus bank offset
    assign waddr = {creq.index, creq.offset[5:2]};
    assign busy  = (count != 4'd0);

    // take the address only when idle
    assign addr_valid = cache_valid && !busy;

    // response in the last counted cycle
    assign data_valid = (count == 4'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count <= 4'd0;
        end else if (addr_valid) begin
            count <= 4'(mem_latency);
        end else if (busy) begin
            count <= count - 4'd1;
        end
    end

    // read and write at acceptance
    always_ff @(posedge clk) begin
        if (addr_valid) begin
            // old word, returned later for loads
            rdata <= mem[waddr];
            if (creq.op == mem_pkg::op_store) begin
                for (int i = 0; i < 4; i++) begin
                    if (creq.write_type[i]) begin
                        mem[waddr][8*i +: 8] <= creq.wdata[8*i +: 8];
                    end
                end
            end
        end
    end

    // single outstanding access
    a_one_pending: assert property (@(posedge clk) disable iff (!arst_n)
        cache_valid |-> !busy);

endmodule

`default_nettype wire

// File: verilog/mem_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module mem_ctrl (
    input  wire                         clk,
    input  wire                         arst_n,
    // execute side
    input  wire                         in_valid,
    input  wire mem_pkg::mem_req_t      in_req,
    output logic                        stall,
    // memory side
    output logic                        cache_valid,
    input  wire cache_pkg::cache_req_t  creq_in,
    input  wire mem_pkg::mem_exc_e      exc_in,
    input  wire                         addr_valid,
    input  wire                         data_valid,
    input  wire [31:0]                  ldata,
    // stage register feeding the address generator
    output mem_pkg::mem_req_t           held_req,
    // write-back side
    output logic                        wb_valid,
    output mem_pkg::mem_wb_t            wb
);

    typedef enum logic [1:0] {
        st_idle,
        st_issue,
        st_wait,
        st_done
    } state_e;

    state_e state;
    logic   accept;
    logic   has_exc;

    // stall blocks new work so only one access is in flight
    assign accept  = in_valid && !stall;
    assign has_exc = (exc_in != mem_pkg::exc_none);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state       <= st_idle;
            stall       <= 1'b0;
            cache_valid <= 1'b0;
            wb_valid    <= 1'b0;
        end else begin
            wb_valid <= 1'b0;
            case (state)
                st_idle, st_done: begin
                    // next access may start right after write-back
                    if (accept) begin
                        state <= st_issue;
                        stall <= 1'b1;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_issue: begin
                    if (has_exc) begin
                        // straight to write-back with memory untouched
                        state    <= st_done;
                        stall    <= 1'b0;
                        wb_valid <= 1'b1;
                    end else begin
                        state       <= st_wait;
                        cache_valid <= 1'b1;
                    end
                end
                st_wait: begin
                    // request holds until the memory takes it
                    cache_valid <= cache_valid && !addr_valid;
                    if (data_valid) begin
                        state    <= st_done;
                        stall    <= 1'b0;
                        wb_valid <= 1'b1;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // stage register and write-back payload
    always_ff @(posedge clk) begin
        if (accept) begin
            held_req <= in_req;
        end
        if (state == st_issue && has_exc) begin
            wb.rd   <= held_req.rd;
            wb.data <= '0;
            wb.exc  <= exc_in;
        end else if (state == st_wait && data_valid) begin
            wb.rd   <= held_req.rd;
            // stores report zero
            wb.data <= (creq_in.op == mem_pkg::op_load) ? ldata : 32'h0;
            wb.exc  <= mem_pkg::exc_none;
        end
    end

    // response only for an access in flight
    a_no_idle_data: assert property (@(posedge clk) disable iff (!arst_n)
        data_valid |-> (state != st_idle));

    // memory accepts only what was requested
    a_addr_with_req: assert property (@(posedge clk) disable iff (!arst_n)
        addr_valid |-> cache_valid);

endmodule

`default_nettype wire

// File: verilog/mem_load_align.sv
`timescale 1ns/1ns
`default_nettype none

module mem_load_align (
    input  wire [31:0]              rdata,
    input  wire [1:0]               offset,
    input  wire mem_pkg::mem_width_e width,
    input  wire                     load_unsigned,
    output logic [31:0]             ldata
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic        byte_sign;
    logic        half_sign;

    // lane picked by the byte offset
    assign byte_sel = rdata[{offset, 3'b000} +: 8];
    // upper or lower half
    assign half_sel = offset[1] ? rdata[31:16] : rdata[15:0];

    // fill bit, zero for unsigned loads
    assign byte_sign = byte_sel[7] & ~load_unsigned;
    assign half_sign = half_sel[15] & ~load_unsigned;

    always_comb begin
        unique case (width)
            mem_pkg::width_byte: begin
                ldata = {{24{byte_sign}}, byte_sel};
            end
            mem_pkg::width_half: begin
                ldata = {{16{half_sign}}, half_sel};
            end
            default: begin
                // whole word as returned
                ldata = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: verilog/mem_addr_gen.sv
`timescale 1ns/1ns
`default_nettype none

module mem_addr_gen (
    input  wire mem_pkg::mem_req_t   req,
    output cache_pkg::cache_req_t    creq,
    output mem_pkg::mem_exc_e        exc
);

    logic [31:0] addr;
    logic        misaligned;

    // effective address
    assign addr = req.base + req.imm;

    always_comb begin
        creq.op = req.op;
        // split into tag, index and offset
        {creq.tag, creq.index, creq.offset} = addr;
        misaligned = 1'b0;
        unique case (req.width)
            mem_pkg::width_byte: begin
                // single lane picked by the byte offset
                creq.write_type = 4'b0001 << addr[1:0];
                creq.wdata      = {4{req.store_data[7:0]}};
            end
            mem_pkg::width_half: begin
                // odd address is illegal
                misaligned      = addr[0];
                creq.write_type = addr[1] ? 4'b1100 : 4'b0011;
                creq.wdata      = {2{req.store_data[15:0]}};
            end
            default: begin
                // word needs both low bits clear
                misaligned      = |addr[1:0];
                creq.write_type = 4'b1111;
                creq.wdata      = req.store_data;
            end
        endcase
    end

    assign exc = misaligned ? mem_pkg::exc_ale : mem_pkg::exc_none;

endmodule

`default_nettype wire

// File: verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    // word address = {index, offset[5:2]}
    localparam int unsigned addr_word_bits = 10;

    // request toward the data cache
    typedef struct packed {
        mem_pkg::mem_op_e op;
        // address bits 31..12
        logic [19:0]      tag;
        // address bits 11..6
        logic [5:0]       index;
        // bank offset in 3..2, byte offset in 1..0
        logic [5:0]       offset;
        // byte write enables
        logic [3:0]       write_type;
        logic [31:0]      wdata;
    } cache_req_t;

endpackage

`default_nettype wire

// File: verilog/mem_pkg.sv
`default_nettype none

package mem_pkg;

    // access width, same code points as the execute stage
    typedef enum logic [1:0] {
        width_byte = 2'b01,
        width_half = 2'b10,
        width_word = 2'b11
    } mem_width_e;

    // read 0, write 1
    typedef enum logic [0:0] {
        op_load  = 1'b0,
        op_store = 1'b1
    } mem_op_e;

    // 6-bit exception code of the pipeline
    typedef enum logic [5:0] {
        exc_none = 6'h00,
        // address alignment error
        exc_ale  = 6'h09
    } mem_exc_e;

    // request handed over by execute
    typedef struct packed {
        mem_op_e     op;
        mem_width_e  width;
        logic        load_unsigned;
        logic [4:0]  rd;
        logic [31:0] base;
        logic [31:0] imm;
        logic [31:0] store_data;
    } mem_req_t;

    // result toward write-back
    typedef struct packed {
        logic [4:0]  rd;
        logic [31:0] data;
        mem_exc_e    exc;
    } mem_wb_t;

endpackage

`default_nettype wire
